/* Makefile */
# Verilator build and run of the synthesizer testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module synth_tb -Mdir obj_dir -f flist.f
	@out=$$(./obj_dir/Vsynth_tb); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

/* flist.f */
hw/synth_pkg.sv
hw/voice_alloc.sv
hw/osc_voice.sv
hw/voice_mixer.sv
hw/synth_top.sv
sim/tb_clock.sv
sim/synth_tb.sv

/* hw/osc_voice.sv */
`timescale 1ns/1ps

module osc_voice import synth_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sample_tick,
    input  logic          voice_load,
    input  logic          voice_gate,
    input  phase_t        voice_incr,
    input  amp_t          voice_amp,
    input  wave_shape_t   voice_shape,
    output voice_sample_t voice_sample,
    output logic          voice_valid
);

    // Running phase
    phase_t phase;

    // Stage 1 registers, captured on the tick
    phase_t      phase_s1;
    logic        gate_s1;
    wave_shape_t shape_s1;
    logic        valid_s1;

    // Sine quarter table and its lookup
    wave_t                        sin_lut [LUT_DEPTH];
    logic [$clog2(LUT_DEPTH)-1:0] lut_idx;
    wave_t                        lut_val;

    // Raw wave and scaled product
    wave_t              wave;
    logic signed [24:0] scaled;

    // ROM contents
    initial begin
        $readmemh("hw/sin_lut.hex", sin_lut);
    end

    ////////////////////
    // Phase accumulator
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            phase <= '0;
        end else if (voice_load) begin
            // New note starts at phase 0
            phase <= '0;
        end else if (sample_tick && voice_gate) begin
            phase <= phase + voice_incr;
        end
    end

    // Stage 1 capture, phase before the add
    always_ff @(posedge clk) begin
        if (sample_tick) begin
            phase_s1 <= phase;
            gate_s1  <= voice_gate;
            shape_s1 <= voice_shape;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_s1    <= 1'b0;
            voice_valid <= 1'b0;
        end else begin
            valid_s1    <= sample_tick;
            voice_valid <= valid_s1;
        end
    end

    ////////////////////
    // Wave shaping
    ////////////////////

    // Second quadrant reads the table backwards
    assign lut_idx = phase_s1[22] ? ($clog2(LUT_DEPTH))'(LUT_DEPTH - 1) - phase_s1[21:16]
                                  : phase_s1[21:16];
    assign lut_val = sin_lut[lut_idx];

    always_comb begin
        case (shape_s1)
            // Offset binary to two's complement ramp
            SAW:     wave = {~phase_s1[23], phase_s1[22:8]};
            SQUARE:  wave = phase_s1[23] ? wave_t'(-WAVE_MAX) : wave_t'(WAVE_MAX);
            // Lower half of the cycle is negated
            SINE:    wave = phase_s1[23] ? -lut_val : lut_val;
            default: wave = '0;
        endcase
    end

    // Unsigned amplitude as a positive signed factor
    assign scaled = wave * $signed({1'b0, voice_amp});

    // Stage 2 output, muted voice still produces a sample
    always_ff @(posedge clk) begin
        if (valid_s1) begin
            voice_sample <= gate_s1 ? voice_sample_t'(scaled >>> AMP_SHIFT) : '0;
        end
    end

endmodule

/* hw/sin_lut.hex */
// One signed 16-bit hex value per line
// Entry i is 32767 * sin(i * pi / 128)
0000
0324
0648
096A
0C8C
0FAB
12C8
15E2
18F9
1C0B
1F1A
2223
2528
2826
2B1F
2E11
30FB
33DF
36BA
398C
3C56
3F17
41CE
447A
471C
49B4
4C3F
4EBF
5133
539B
55F5
5842
5A82
5CB3
5ED7
60EB
62F1
64E8
66CF
68A6
6A6D
6C23
6DC9
6F5E
70E2
7254
73B5
7504
7641
776B
7884
7989
7A7C
7B5C
7C29
7CE3
7D89
7E1D
7E9C
7F09
7F61
7FA6
7FD8
7FF5

/* hw/synth_pkg.sv */
package synth_pkg;

    ////////////////////
    // Core sizing
    ////////////////////

    // Oscillator voice count
    localparam int NUM_VOICES = 4;

    // Phase step per Hz, 2^24 over 48 kHz
    localparam int PHASE_PER_HZ = 350;

    // Quarter-wave sine table length
    localparam int LUT_DEPTH = 64;

    // Positive full scale of a raw wave
    localparam int WAVE_MAX = 32767;

    // Right shift after the amplitude multiply
    localparam int AMP_SHIFT = 8;

    // Mixer accumulator width, room for four voices
    localparam int MIX_WIDTH = 18;

    ////////////////////
    // Data types
    ////////////////////

    // Note frequency in Hz
    typedef logic [15:0] freq_t;

    // Amplitude, 255 is close to full scale
    typedef logic [7:0] amp_t;

    // Phase accumulator and increment
    typedef logic [23:0] phase_t;

    // Raw wave before scaling
    typedef logic signed [15:0] wave_t;

    // Scaled output of one voice
    typedef logic signed [15:0] voice_sample_t;

    // Mixed and clamped output
    typedef logic signed [15:0] sample_t;

    // Waveform selection
    typedef enum logic [1:0] {
        SAW    = 2'd0,
        SQUARE = 2'd1,
        SINE   = 2'd2,
        SILENT = 2'd3
    } wave_shape_t;

endpackage

/* hw/synth_top.sv */
`timescale 1ns/1ps

module synth_top import synth_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  sample_tick,
    input  logic                  note_on,
    input  logic                  note_off,
    input  freq_t                 note_freq,
    input  amp_t                  note_amp,
    input  wave_shape_t           note_shape,
    output sample_t               sample_out,
    output logic                  sample_valid,
    output logic                  note_dropped,
    output logic [NUM_VOICES-1:0] voices_active
);

    // Allocator to voices
    logic [NUM_VOICES-1:0] voice_load;
    logic [NUM_VOICES-1:0] voice_gate;
    phase_t                voice_incr [NUM_VOICES];
    amp_t                  voice_amp [NUM_VOICES];
    wave_shape_t           voice_shape [NUM_VOICES];

    // Voices to mixer
    voice_sample_t         voice_sample [NUM_VOICES];
    logic [NUM_VOICES-1:0] voice_valid;

    ////////////////////
    // Note allocation
    ////////////////////

    voice_alloc voice_alloc_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .note_on       (note_on),
        .note_off      (note_off),
        .note_freq     (note_freq),
        .note_amp      (note_amp),
        .note_shape    (note_shape),
        .note_dropped  (note_dropped),
        .voices_active (voices_active),
        .voice_load    (voice_load),
        .voice_gate    (voice_gate),
        .voice_incr    (voice_incr),
        .voice_amp     (voice_amp),
        .voice_shape   (voice_shape)
    );

    ////////////////////
    // Oscillator voices
    ////////////////////

    for (genvar i = 0; i < NUM_VOICES; i++) begin : g_voice
        osc_voice osc_voice_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .sample_tick  (sample_tick),
            .voice_load   (voice_load[i]),
            .voice_gate   (voice_gate[i]),
            .voice_incr   (voice_incr[i]),
            .voice_amp    (voice_amp[i]),
            .voice_shape  (voice_shape[i]),
            .voice_sample (voice_sample[i]),
            .voice_valid  (voice_valid[i])
        );
    end

    // Sum of all voices
    voice_mixer voice_mixer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .voice_sample (voice_sample),
        .voice_valid  (voice_valid),
        .sample_out   (sample_out),
        .sample_valid (sample_valid)
    );

endmodule

/* hw/voice_alloc.sv */
`timescale 1ns/1ps

module voice_alloc import synth_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  note_on,
    input  logic                  note_off,
    input  freq_t                 note_freq,
    input  amp_t                  note_amp,
    input  wave_shape_t           note_shape,
    output logic                  note_dropped,
    output logic [NUM_VOICES-1:0] voices_active,
    output logic [NUM_VOICES-1:0] voice_load,
    output logic [NUM_VOICES-1:0] voice_gate,
    output phase_t                voice_incr [NUM_VOICES],
    output amp_t                  voice_amp [NUM_VOICES],
    output wave_shape_t           voice_shape [NUM_VOICES]
);

    // Frequency each voice was started with, for note-off matching
    freq_t voice_freq [NUM_VOICES];

    // Free voices and the one picked for note-on
    logic [NUM_VOICES-1:0] idle;
    logic [NUM_VOICES-1:0] on_sel;

    // Busy voices playing note_freq, and the one picked for note-off
    logic [NUM_VOICES-1:0] off_match;
    logic [NUM_VOICES-1:0] off_sel;

    // Gate changes requested this cycle
    logic [NUM_VOICES-1:0] gate_set;
    logic [NUM_VOICES-1:0] gate_clr;

    // Phase step for the incoming note
    phase_t new_incr;

    ////////////////////
    // Voice selection
    ////////////////////

    always_comb begin
        idle = ~voice_gate;
        // Isolate lowest set bit
        on_sel = idle & (~idle + 1'b1);

        for (int i = 0; i < NUM_VOICES; i++) begin
            off_match[i] = voice_gate[i] && (voice_freq[i] == note_freq);
        end
        off_sel = off_match & (~off_match + 1'b1);

        // Both strobes look at the gates from before this cycle
        gate_set = note_on ? on_sel : '0;
        gate_clr = note_off ? off_sel : '0;
    end

    // Hz to phase step, upper bits fall off
    assign new_incr = phase_t'(note_freq * PHASE_PER_HZ);

    ////////////////////
    // Control state
    ////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            voice_gate   <= '0;
            voice_load   <= '0;
            note_dropped <= 1'b0;
        end else begin
            voice_gate   <= (voice_gate | gate_set) & ~gate_clr;
            // One-cycle load strobe to the chosen voice
            voice_load   <= gate_set;
            // No free voice, note is lost
            note_dropped <= note_on && (idle == '0);
        end
    end

    // Mask seen by the host
    assign voices_active = voice_gate;

    ////////////////////
    // Per-voice settings
    ////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (gate_set[i]) begin
                voice_incr[i]  <= new_incr;
                voice_amp[i]   <= note_amp;
                voice_shape[i] <= note_shape;
                voice_freq[i]  <= note_freq;
            end
        end
    end

endmodule

/* hw/voice_mixer.sv */
`timescale 1ns/1ps

module voice_mixer import synth_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  voice_sample_t         voice_sample [NUM_VOICES],
    input  logic [NUM_VOICES-1:0] voice_valid,
    output sample_t               sample_out,
    output logic                  sample_valid
);

    // Wide sum, cannot overflow for four voices
    logic signed [MIX_WIDTH-1:0] sum;

    // Sum after clamping
    sample_t sat;

    ////////////////////
    // Sum and clamp
    ////////////////////

    always_comb begin
        sum = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            // Sign extend each voice
            sum = sum + MIX_WIDTH'(voice_sample[i]);
        end
    end

    always_comb begin
        if (sum > WAVE_MAX) begin
            sat = sample_t'(WAVE_MAX);
        end else if (sum < -WAVE_MAX - 1) begin
            sat = sample_t'(-WAVE_MAX - 1);
        end else begin
            sat = sample_t'(sum);
        end
    end

    ////////////////////
    // Output register
    ////////////////////

    // Voices share the tick, voice 0 valid stands for all
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_out   <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= voice_valid[0];
            if (voice_valid[0]) begin
                sample_out <= sat;
            end
        end
    end

endmodule

/* sim/synth_tb.sv */
`timescale 1ns/1ps

module synth_tb import synth_pkg::*; ();

    // Idle cycles before each tick, tick to output latency, run budget
    localparam int TICK_GAP    = 17;
    localparam int VALID_DELAY = 3;
    localparam int WATCHDOG_NS = 200 * 20 * 4 + 4000;

    logic                  clk;
    logic                  rst_n;
    logic                  sample_tick;
    logic                  note_on;
    logic                  note_off;
    freq_t                 note_freq;
    amp_t                  note_amp;
    wave_shape_t           note_shape;
    sample_t               sample_out;
    logic                  sample_valid;
    logic                  note_dropped;
    logic [NUM_VOICES-1:0] voices_active;

    // Reference model, one entry per voice
    logic [NUM_VOICES-1:0] m_gate;
    phase_t                m_phase [NUM_VOICES];
    phase_t                m_incr [NUM_VOICES];
    amp_t                  m_amp [NUM_VOICES];
    wave_shape_t           m_shape [NUM_VOICES];
    freq_t                 m_freq [NUM_VOICES];
    wave_t                 sine_table [LUT_DEPTH];

    integer seed;
    int     value_errors;
    int     other_errors;
    int     samples_checked;
    int     last_sample;
    int     clamps_high;
    int     clamps_low;
    string  test_name;

    tb_clock tb_clock_i (
        .clk (clk)
    );

    synth_top synth_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .sample_tick   (sample_tick),
        .note_on       (note_on),
        .note_off      (note_off),
        .note_freq     (note_freq),
        .note_amp      (note_amp),
        .note_shape    (note_shape),
        .sample_out    (sample_out),
        .sample_valid  (sample_valid),
        .note_dropped  (note_dropped),
        .voices_active (voices_active)
    );

    ////////////////////
    // Checks
    ////////////////////

    task automatic check_value(input string what, input int expected, input int actual);
        assert (expected == actual) else begin
            value_errors++;
            $display("ERROR %s: %s expected %0d actual %0d", test_name, what, expected, actual);
        end
    endtask

    task automatic check_true(input bit ok, input string problem);
        assert (ok) else begin
            other_errors++;
            $display("Failure in %s: %s", test_name, problem);
        end
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int wave_of(input phase_t ph, input wave_shape_t shape);
        int idx;
        int val;
        idx = ph[21:16];
        val = 0;
        case (shape)
            // Ramp from -32768 up to 32767 over one cycle
            SAW:    val = int'(ph[23:8]) - 32768;
            SQUARE: val = ph[23] ? -WAVE_MAX : WAVE_MAX;
            SINE: begin
                // Second and fourth quarter run the table backwards
                if (ph[22]) begin
                    idx = LUT_DEPTH - 1 - idx;
                end
                val = ph[23] ? -int'(sine_table[idx]) : int'(sine_table[idx]);
            end
            default: val = 0;
        endcase
        return val;
    endfunction

    // Expected mix for one tick, then advance the phases
    task automatic model_tick(output int expected);
        int sum;
        sum = 0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            if (m_gate[i]) begin
                sum += (wave_of(m_phase[i], m_shape[i]) * int'(m_amp[i])) >>> 8;
                m_phase[i] = m_phase[i] + m_incr[i];
            end
        end
        expected = (sum > WAVE_MAX) ? WAVE_MAX : (sum < -WAVE_MAX - 1) ? -WAVE_MAX - 1 : sum;
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    // Tick, then wait for the mixed sample and compare it
    task automatic run_ticks(input int count);
        int expected;
        int waited;
        repeat (count) begin
            repeat (TICK_GAP) begin
                @(posedge clk);
                #1;
                check_true(!sample_valid, "sample_valid pulsed with no tick pending");
                check_value("held sample_out", last_sample, sample_out);
            end
            model_tick(expected);
            sample_tick = 1'b1;
            waited = 0;
            while (!sample_valid && waited < VALID_DELAY + 4) begin
                @(posedge clk);
                #1;
                sample_tick = 1'b0;
                waited++;
            end
            check_true(sample_valid, "no sample_valid followed the tick");
            if (sample_valid) begin
                check_value("sample_valid delay", VALID_DELAY, waited);
                check_value("sample_out", expected, sample_out);
                // Output pinned at either rail
                if (sample_out == WAVE_MAX) begin
                    clamps_high++;
                end
                if (sample_out == -WAVE_MAX - 1) begin
                    clamps_low++;
                end
                last_sample = sample_out;
                samples_checked++;
            end
        end
    endtask

    // One note-on or note-off strobe, mirrored in the model
    task automatic send_note(input bit on, input freq_t freq, input amp_t amp,
                             input wave_shape_t shape);
        int slot;
        slot = -1;
        for (int i = NUM_VOICES - 1; i >= 0; i--) begin
            // Last hit is the lowest qualifying index
            if (on ? !m_gate[i] : (m_gate[i] && m_freq[i] == freq)) begin
                slot = i;
            end
        end
        if (slot >= 0 && !on) begin
            m_gate[slot] = 1'b0;
        end else if (slot >= 0) begin
            m_gate[slot]  = 1'b1;
            m_phase[slot] = '0;
            m_incr[slot]  = phase_t'(int'(freq) * PHASE_PER_HZ);
            m_amp[slot]   = amp;
            m_shape[slot] = shape;
            m_freq[slot]  = freq;
        end
        note_freq  = freq;
        note_amp   = amp;
        note_shape = shape;
        note_on    = on;
        note_off   = !on;
        @(posedge clk);
        #1;
        note_on  = 1'b0;
        note_off = 1'b0;
        check_value("voices_active", m_gate, voices_active);
        check_value("note_dropped", on && slot < 0, note_dropped);
        @(posedge clk);
        #1;
        check_true(!note_dropped, "note_dropped lasted more than one cycle");
        check_value("voices_active a cycle later", m_gate, voices_active);
    endtask

    initial begin
        freq_t freq;
        freq_t chord [NUM_VOICES];
        seed            = 32'h90c7c928;
        value_errors    = 0;
        other_errors    = 0;
        samples_checked = 0;
        last_sample     = 0;
        m_gate          = '0;
        for (int i = 0; i < NUM_VOICES; i++) begin
            m_phase[i] = '0;
            m_incr[i]  = '0;
            m_amp[i]   = '0;
            m_shape[i] = SILENT;
            m_freq[i]  = '0;
        end
        $readmemh("hw/sin_lut.hex", sine_table);
        rst_n       = 1'b0;
        sample_tick = 1'b0;
        note_on     = 1'b0;
        note_off    = 1'b0;
        note_freq   = '0;
        note_amp    = '0;
        note_shape  = SAW;
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;

        // Idle core after reset
        test_name = "reset";
        check_value("voices_active", 0, voices_active);
        check_value("sample_out", 0, sample_out);
        check_true(!sample_valid && !note_dropped, "a strobe is high after reset");
        run_ticks(4);

        // Each shape alone on voice 0
        test_name = "single_voice";
        for (int s = 0; s < 4; s++) begin
            freq = freq_t'(2000 + $unsigned($random(seed)) % 4000);
            send_note(1'b1, freq, amp_t'($random(seed)), wave_shape_t'(s));
            check_value("voice 0 mask", 1, voices_active);
            run_ticks(16);
            send_note(1'b0, freq, '0, SAW);
        end

        // Voices fill lowest first and the fifth note is lost
        test_name = "allocation";
        for (int v = 0; v <= NUM_VOICES; v++) begin
            send_note(1'b1, freq_t'(220 + 110 * v), amp_t'(40 + 30 * v), wave_shape_t'(v % 3));
            check_value("fill mask", (1 << (v < NUM_VOICES ? v + 1 : NUM_VOICES)) - 1,
                        voices_active);
        end
        run_ticks(4);

        test_name = "note_off";
        send_note(1'b0, 330, '0, SAW);
        check_value("mask after release", 4'b1101, voices_active);
        // Nobody plays 999 Hz
        send_note(1'b0, 999, '0, SAW);
        check_value("mask after unmatched release", 4'b1101, voices_active);
        run_ticks(3);
        send_note(1'b1, 880, 120, SAW);
        check_value("freed voice reused", 4'b1111, voices_active);
        run_ticks(6);
        chord = '{220, 440, 550, 880};
        for (int v = 0; v < NUM_VOICES; v++) begin
            send_note(1'b0, chord[v], '0, SAW);
        end
        check_value("all released", 0, voices_active);

        // Four full-scale squares in phase overflow both ways
        test_name   = "saturation";
        clamps_high = 0;
        clamps_low  = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            send_note(1'b1, 4000, 255, SQUARE);
        end
        run_ticks(24);
        check_true(clamps_high > 0 && clamps_low > 0,
                   "sample_out never sat at both clamp limits");
        for (int v = 0; v < NUM_VOICES; v++) begin
            send_note(1'b0, 4000, '0, SAW);
        end

        // Low amplitudes keep the sum in range
        test_name   = "mixed";
        clamps_high = 0;
        clamps_low  = 0;
        for (int v = 0; v < NUM_VOICES; v++) begin
            chord[v] = freq_t'(300 + 400 * v + $unsigned($random(seed)) % 200);
            send_note(1'b1, chord[v], amp_t'($unsigned($random(seed)) % 61), wave_shape_t'(v));
        end
        run_ticks(20);
        check_true(clamps_high + clamps_low == 0, "sample_out hit a clamp limit on an in-range mix");
        for (int v = 0; v < NUM_VOICES; v++) begin
            send_note(1'b0, chord[v], '0, SAW);
        end
        check_value("all released", 0, voices_active);

        $display("Summary: %0d value errors, %0d other errors, %0d samples checked",
                 value_errors, other_errors, samples_checked);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns and the run did not finish", WATCHDOG_NS);
        $display("Summary: %0d value errors, %0d other errors, %0d samples checked",
                 value_errors, other_errors, samples_checked);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* sim/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    // 4 ns period, 2 ns per half
    initial begin
        clk = 1'b0;
        forever begin
            #2;
            clk = ~clk;
        end
    end

endmodule
